//--- verilog/icache_pkg.sv
package icache_pkg;

    // Bus widths shared by the core, the cache and the memory
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // Byte offset inside one instruction word
    localparam int BYTE_OFFSET_W = 2;

    // Byte address of a fetch or a memory request
    typedef logic [ADDR_W-1:0] addr_t;

    // One instruction word
    typedef logic [WORD_W-1:0] word_t;

    // Fetch controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REQUEST,
        ST_REFILL,
        ST_RESPOND
    } cache_state_t;

endpackage

//--- verilog/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store
    import icache_pkg::*;
#(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                        Clk,
    input  logic                        rst,
    input  addr_t                       lookup_addr,
    input  logic                        fill_en,
    input  logic [$clog2(NUM_WAYS)-1:0] fill_way,
    input  addr_t                       fill_addr,
    input  logic                        flush,
    output logic                        hit,
    output logic [$clog2(NUM_WAYS)-1:0] hit_way,
    output logic [NUM_WAYS-1:0]         set_valid
);

    localparam int OFFSET_W = BYTE_OFFSET_W + $clog2(BLOCK_WORDS);
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAY_W    = $clog2(NUM_WAYS);

    logic [TAG_W-1:0]    tags  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];

    logic [INDEX_W-1:0]  lookup_index;
    logic [TAG_W-1:0]    lookup_tag;
    logic [INDEX_W-1:0]  fill_index;
    logic [TAG_W-1:0]    fill_tag;
    logic [NUM_WAYS-1:0] match;
    logic [WAY_W-1:0]    match_way;
    logic                dup_tag;

    assign lookup_index = lookup_addr[OFFSET_W +: INDEX_W];
    assign lookup_tag   = lookup_addr[ADDR_W-1 -: TAG_W];
    assign fill_index   = fill_addr[OFFSET_W +: INDEX_W];
    assign fill_tag     = fill_addr[ADDR_W-1 -: TAG_W];

    // All ways of the indexed set compared at once
    always_comb begin
        match     = '0;
        match_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (valid[lookup_index][w] && (tags[lookup_index][w] == lookup_tag)) begin
                match[w]  = 1'b1;
                match_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (flush) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_en) begin
            valid[fill_index][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill_en) begin
            tags[fill_index][fill_way] <= fill_tag;
        end
    end

    // Result seen by the controller one cycle after the address
    always_ff @(posedge Clk) begin
        if (rst || flush) begin
            hit       <= 1'b0;
            hit_way   <= '0;
            set_valid <= '0;
        end else begin
            hit       <= |match;
            hit_way   <= match_way;
            set_valid <= valid[lookup_index];
        end
    end

    always_comb begin
        dup_tag = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int a = 0; a < NUM_WAYS; a++) begin
                for (int b = a + 1; b < NUM_WAYS; b++) begin
                    if (valid[s][a] && valid[s][b] && (tags[s][a] == tags[s][b])) begin
                        dup_tag = 1'b1;
                    end
                end
            end
        end
    end

    // A block lives in at most one way of its set
    assert property (@(posedge Clk) disable iff (rst) !dup_tag)
        else $error("tag store holds the same block in two ways");

endmodule

//--- verilog/icache_victim_select.sv
`timescale 1ns/1ps

module icache_victim_select #(
    parameter int NUM_SETS = 8,
    parameter int NUM_WAYS = 4
) (
    input  logic                        Clk,
    input  logic                        rst,
    input  logic [$clog2(NUM_SETS)-1:0] set_index,
    input  logic [NUM_WAYS-1:0]         set_valid,
    input  logic                        advance,
    output logic [$clog2(NUM_WAYS)-1:0] victim_way
);

    localparam int WAY_W = $clog2(NUM_WAYS);

    logic [WAY_W-1:0] rr_ptr [NUM_SETS];
    logic             found_invalid;

    // Lowest invalid way first, else the set's pointer
    always_comb begin
        victim_way    = rr_ptr[set_index];
        found_invalid = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found_invalid && !set_valid[w]) begin
                victim_way    = WAY_W'(w);
                found_invalid = 1'b1;
            end
        end
    end

    // Pointer only moves when a full set is refilled
    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (advance && (&set_valid)) begin
            rr_ptr[set_index] <= rr_ptr[set_index] + 1'b1;
        end
    end

endmodule

//--- verilog/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic  Clk,
    input  logic  rst,
    input  logic  fetch_valid,
    input  addr_t fetch_addr,
    input  logic  flush,
    input  word_t mem_data,
    input  logic  mem_valid,
    output word_t instr,
    output logic  instr_valid,
    output logic  busy,
    output addr_t mem_addr,
    output logic  mem_req
);

    localparam int WORD_SEL_W = $clog2(BLOCK_WORDS);
    localparam int OFFSET_W   = BYTE_OFFSET_W + WORD_SEL_W;
    localparam int INDEX_W    = $clog2(NUM_SETS);
    localparam int WAY_W      = $clog2(NUM_WAYS);

    cache_state_t          state;
    addr_t                 addr_q;
    addr_t                 lookup_addr;
    logic [WAY_W-1:0]      victim_q;
    logic [WORD_SEL_W-1:0] word_cnt;
    logic [INDEX_W-1:0]    set_index;
    logic [WORD_SEL_W-1:0] word_sel;
    logic                  accept;
    logic                  last_word;
    logic                  fill_en;
    logic                  hit;
    logic [WAY_W-1:0]      hit_way;
    logic [NUM_WAYS-1:0]   set_valid;
    logic [WAY_W-1:0]      victim_way;

    word_t data_arr [NUM_SETS][NUM_WAYS][BLOCK_WORDS];

    // The respond cycle already takes a new fetch
    assign busy      = (state == ST_LOOKUP) || (state == ST_REQUEST) || (state == ST_REFILL);
    assign accept    = fetch_valid && !busy;
    assign lookup_addr = busy ? addr_q : fetch_addr;

    assign set_index = addr_q[OFFSET_W +: INDEX_W];
    assign word_sel  = addr_q[BYTE_OFFSET_W +: WORD_SEL_W];
    assign last_word = mem_valid && (word_cnt == WORD_SEL_W'(BLOCK_WORDS - 1));
    assign fill_en   = (state == ST_REFILL) && last_word;

    assign mem_req     = (state == ST_REQUEST);
    assign mem_addr    = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign instr_valid = (state == ST_RESPOND);

    icache_tag_store #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_tag_store (
        .Clk         (Clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_way    (victim_q),
        .fill_addr   (addr_q),
        .flush       (flush && !busy),
        .hit         (hit),
        .hit_way     (hit_way),
        .set_valid   (set_valid)
    );

    icache_victim_select #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS)
    ) u_victim_select (
        .Clk        (Clk),
        .rst        (rst),
        .set_index  (set_index),
        .set_valid  (set_valid),
        .advance    (fill_en),
        .victim_way (victim_way)
    );

    always_ff @(posedge Clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_RESPOND: begin
                    state <= accept ? ST_LOOKUP : ST_IDLE;
                end
                ST_LOOKUP: begin
                    state <= hit ? ST_RESPOND : ST_REQUEST;
                end
                ST_REQUEST: begin
                    state    <= ST_REFILL;
                    word_cnt <= '0;
                end
                ST_REFILL: begin
                    if (mem_valid) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    if (last_word) begin
                        state <= ST_RESPOND;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address, victim, data array and returned word
    always_ff @(posedge Clk) begin
        if (accept) begin
            addr_q <= fetch_addr;
        end
        if (state == ST_LOOKUP) begin
            victim_q <= victim_way;
            instr    <= data_arr[set_index][hit_way][word_sel];
        end
        if ((state == ST_REFILL) && mem_valid) begin
            data_arr[set_index][victim_q][word_cnt] <= mem_data;
            // requested word caught on its way past
            if (word_cnt == word_sel) begin
                instr <= mem_data;
            end
        end
    end

    // Memory only answers a request made from this controller
    assert property (@(posedge Clk) disable iff (rst) mem_valid |-> (state == ST_REFILL))
        else $error("mem_valid outside a refill");

    assert property (@(posedge Clk) disable iff (rst) !(instr_valid && mem_req))
        else $error("instr_valid together with mem_req");

endmodule

//--- verilog/instr_mem.sv
`timescale 1ns/1ps

module instr_mem
    import icache_pkg::*;
#(
    parameter int MEM_WORDS   = 1024,
    parameter int BLOCK_WORDS = 4,
    parameter int MEM_LATENCY = 6
) (
    input  logic  Clk,
    input  logic  rst,
    input  logic  load_valid,
    input  addr_t load_addr,
    input  word_t load_data,
    input  logic  mem_req,
    input  addr_t mem_addr,
    output word_t mem_data,
    output logic  mem_valid
);

    localparam int LAT_W  = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
    localparam int BEAT_W = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;

    word_t mem [MEM_WORDS];

    logic              active;
    logic [LAT_W-1:0]  wait_cnt;
    logic [BEAT_W-1:0] beat;
    addr_t             base_q;
    addr_t             burst_addr;

    // Addresses wrap around the array
    function automatic int unsigned word_index(addr_t a);
        return (a >> BYTE_OFFSET_W) % MEM_WORDS;
    endfunction

    always_ff @(posedge Clk) begin
        if (load_valid) begin
            mem[word_index(load_addr)] <= load_data;
        end
    end

    assign burst_addr = base_q + (addr_t'(beat) << BYTE_OFFSET_W);
    assign mem_valid  = active && (wait_cnt == '0);
    assign mem_data   = mem[word_index(burst_addr)];

    // Latency countdown, then one word per cycle
    always_ff @(posedge Clk) begin
        if (rst) begin
            active   <= 1'b0;
            wait_cnt <= '0;
            beat     <= '0;
        end else if (mem_req) begin
            active   <= 1'b1;
            wait_cnt <= LAT_W'(MEM_LATENCY - 1);
            beat     <= '0;
        end else if (active) begin
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                beat <= beat + 1'b1;
                if (beat == BEAT_W'(BLOCK_WORDS - 1)) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (mem_req) begin
            base_q <= mem_addr;
        end
    end

    // The cache waits for a whole block before asking again
    assert property (@(posedge Clk) disable iff (rst) mem_req |-> !active)
        else $error("mem_req during an active burst");

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
#(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 6
) (
    input  logic  Clk,
    input  logic  rst,
    input  logic  fetch_valid,
    input  addr_t fetch_addr,
    input  logic  flush,
    input  logic  load_valid,
    input  addr_t load_addr,
    input  word_t load_data,
    output word_t instr,
    output logic  instr_valid,
    output logic  busy
);

    // Refill path between cache and memory
    logic  mem_req;
    addr_t mem_addr;
    word_t mem_data;
    logic  mem_valid;

    icache_ctrl #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_ctrl (
        .Clk         (Clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .flush       (flush),
        .mem_data    (mem_data),
        .mem_valid   (mem_valid),
        .instr       (instr),
        .instr_valid (instr_valid),
        .busy        (busy),
        .mem_addr    (mem_addr),
        .mem_req     (mem_req)
    );

    instr_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .BLOCK_WORDS (BLOCK_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .Clk        (Clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .mem_valid  (mem_valid)
    );

endmodule

//--- test/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 100;
    localparam int QUIET_CYCLES   = 20;
    localparam int HIT_LATENCY    = 2;

    logic  Clk;
    logic  rst;
    logic  fetch_valid;
    addr_t fetch_addr;
    logic  flush;
    logic  load_valid;
    addr_t load_addr;
    word_t load_data;
    word_t instr;
    logic  instr_valid;
    logic  busy;

    int tests_run;
    int tests_failed;
    int test_errors;
    bit aborted;
    int seed;

    icache_top u_dut (
        .Clk         (Clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .flush       (flush),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .instr       (instr),
        .instr_valid (instr_valid),
        .busy        (busy)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s %s expected %h actual %h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic load_word(input addr_t addr, input word_t data);
        @(posedge Clk);
        load_valid <= 1'b1;
        load_addr  <= addr;
        load_data  <= data;
        @(posedge Clk);
        load_valid <= 1'b0;
    endtask

    task automatic flush_cache();
        @(posedge Clk);
        flush <= 1'b1;
        @(posedge Clk);
        flush <= 1'b0;
    endtask

    // Cycle count starts with the strobe cycle as zero
    task automatic run_fetch(input string name, input addr_t addr, input word_t exp_word,
                             input string exp_kind, input bit strobe_busy, input addr_t extra_addr);
        int cycles;
        int extra_valid;
        bit done;
        test_errors = 0;
        done        = 1'b0;
        @(posedge Clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        @(posedge Clk);
        fetch_valid <= 1'b0;
        cycles = 1;
        while (!done && !aborted) begin
            @(negedge Clk);
            if (instr_valid) begin
                done = 1'b1;
                check_value(name, "instr", exp_word, instr);
                check_value(name, "busy at response", 0, busy);
            end else if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: fetch %s got no instr_valid within %0d cycles",
                         name, TIMEOUT_CYCLES);
                test_errors++;
                aborted = 1'b1;
            end else begin
                check_value(name, "busy", 1, busy);
                @(posedge Clk);
                // Second strobe lands in the request cycle
                if (strobe_busy && (cycles == 1)) begin
                    fetch_valid <= 1'b1;
                    fetch_addr  <= extra_addr;
                end else begin
                    fetch_valid <= 1'b0;
                end
                cycles++;
            end
        end
        if (done) begin
            if (exp_kind == "H") begin
                check_value(name, "latency", HIT_LATENCY, cycles);
            end else begin
                check_value(name, "latency above 2", 1, cycles > HIT_LATENCY);
            end
        end
        if (done && strobe_busy) begin
            extra_valid = 0;
            repeat (QUIET_CYCLES) begin
                @(negedge Clk);
                if (instr_valid) begin
                    extra_valid++;
                end
            end
            check_value(name, "extra instr_valid count", 0, extra_valid);
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic bad_line(input string line);
        $display("Unreadable line in the tests file: %s", line);
        aborted = 1'b1;
    endtask

    task automatic run_command(input string line, input string verb);
        string word0;
        string name;
        string kind;
        addr_t a;
        addr_t a2;
        word_t d;
        int    n;
        // A few idle cycles between commands
        repeat ($unsigned($random(seed)) % 3) @(posedge Clk);
        if (verb == "load") begin
            n = $sscanf(line, "%s %h %h", word0, a, d);
            if (n == 3) begin
                load_word(a, d);
            end else begin
                bad_line(line);
            end
        end else if (verb == "flush") begin
            flush_cache();
        end else if (verb == "fetch") begin
            n = $sscanf(line, "%s %s %h %h %s", word0, name, a, d, kind);
            if (n == 5) begin
                run_fetch(name, a, d, kind, 1'b0, '0);
            end else begin
                bad_line(line);
            end
        end else if (verb == "busy") begin
            n = $sscanf(line, "%s %s %h %h %s %h", word0, name, a, d, kind, a2);
            if (n == 6) begin
                run_fetch(name, a, d, kind, 1'b1, a2);
            end else begin
                bad_line(line);
            end
        end else begin
            bad_line(line);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        string verb;
        rst          = 1'b1;
        fetch_valid  = 1'b0;
        fetch_addr   = '0;
        flush        = 1'b0;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        aborted      = 1'b0;
        seed         = 42380;
        repeat (RESET_CYCLES) @(posedge Clk);
        rst <= 1'b0;

        fd = $fopen("test/icache_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/icache_tests.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && !$feof(fd)) begin
                line = "";
                verb = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s", verb);
                end
                if ((n > 0) && (verb[0] != "#")) begin
                    run_command(line, verb);
                end
            end
            $fclose(fd);
        end

        $display("Tests: %0d run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if ((tests_failed == 0) && !aborted && (tests_run > 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
verilog/icache_pkg.sv
verilog/icache_tag_store.sv
verilog/icache_victim_select.sv
verilog/icache_ctrl.sv
verilog/instr_mem.sv
verilog/icache_top.sv
test/icache_tb.sv

//--- test/icache_tests.txt
# load <addr> <word> | flush | fetch <name> <addr> <expected word> <H|M>
# busy <name> <addr> <expected word> <H|M> <addr strobed while busy>
load 00000000 00000013
load 00000004 00100093
load 0000000c 00308193
load 00000080 08000213
load 00000100 10000293
load 00000180 18000313
load 00000200 20000393
load 00000300 30000413
load 0000030c 30c00493
load 000003a0 3a000513
load 000003a8 3a800593
load 000001d4 1d400613
load 000001dc 1dc00693
load 000006f0 6f000713
load 0000095c 95c00793
load 00000c14 c1400813
# Cold miss, then hits in the same block
fetch cold_miss 00000000 00000013 M
fetch same_block_w1 00000004 00100093 H
fetch same_block_w3 0000000c 00308193 H
# Five blocks into set 0
fetch set0_fill_w1 00000080 08000213 M
fetch set0_fill_w2 00000100 10000293 M
fetch set0_fill_w3 00000180 18000313 M
fetch set0_evict_w0 00000200 20000393 M
fetch set0_refetch_first 00000000 00000013 M
fetch set0_keep_100 00000100 10000293 H
fetch set0_keep_180 00000180 18000313 H
fetch set0_keep_200 00000200 20000393 H
fetch set0_evicted_080 00000080 08000213 M
# Flush, then new code at 0x004
fetch pre_flush_hit 00000004 00100093 H
flush
load 00000004 00a00093
fetch post_flush_miss 00000004 00a00093 M
fetch post_flush_hit 00000000 00000013 H
# Second strobe during the refill is dropped
busy busy_drop 00000300 30000413 M 00000004
fetch after_busy_hit 00000004 00a00093 H
# Spread over several sets
fetch mix_set2_miss 000003a8 3a800593 M
fetch mix_set5_miss 000001d4 1d400613 M
fetch mix_set7_miss 000006f0 6f000713 M
fetch mix_set2_hit 000003a0 3a000513 H
fetch mix_set5_way1 0000095c 95c00793 M
fetch mix_set5_hit 000001dc 1dc00693 H
fetch mix_set1_miss 00000c14 c1400813 M
fetch mix_set0_hit 0000030c 30c00493 H
